// ==== files.f ====
+incdir+.
noc_pkg.sv
flit_fifo.sv
output_arbiter.sv
router_top.sv
torus_topology.sv
tb_torus.sv

// ==== flit_fifo.sv ====
// Input FIFO for one router port; push while full is not checked, the sender must respect credits
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module flit_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  noc_pkg::flit_t push_data,
    input  logic           pop,
    output logic           head_valid,
    output noc_pkg::flit_t head_data,
    output logic           credit_out
);
    import noc_pkg::*;

    localparam int PTR_W = (`BUFFER_DEPTH > 1) ? $clog2(`BUFFER_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`BUFFER_DEPTH - 1);

    flit_t            mem [`BUFFER_DEPTH-1:0];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_cnt_t      count;
    logic             do_pop;

    // Head is visible straight from the buffer, no output stage
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit pulse per popped flit, a cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== noc_macros.svh ====
// Port indices, flit layout and buffer depth shared by all NoC blocks; ids above 255 do not fit
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Router port indices, neighbor ports use index minus one for credits
`define NIC_PORT 0
`define NORTH    1
`define SOUTH    2
`define EAST     3
`define WEST     4

`define NUM_PORTS 5

// Flit layout, destination id in the top byte
`define FLIT_DATA_WIDTH 32
`define DEST_WIDTH      8

// Input FIFO depth and initial credit count
`define BUFFER_DEPTH 4

// Default torus size
`define DEFAULT_ROWS 3
`define DEFAULT_COLS 3

`endif

// ==== noc_pkg.sv ====
// NoC types; credit_cnt_t holds BUFFER_DEPTH only while the depth stays below 8
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    // One flit, destination id in the upper DEST_WIDTH bits
    typedef logic [`FLIT_DATA_WIDTH-1:0] flit_t;

    // Router id, row major over the grid
    typedef logic [`DEST_WIDTH-1:0] node_id_t;

    // Index of one of the five router ports
    typedef logic [2:0] port_idx_t;

    // Credits toward one downstream buffer, also FIFO fill level
    typedef logic [2:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== output_arbiter.sv ====
// Round-robin arbiter and credit counter for one output; counter saturates at BUFFER_DEPTH
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module output_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`NUM_PORTS-1:0] request,
    input  logic                  credit_in,
    output logic [`NUM_PORTS-1:0] grant,
    output logic                  grant_valid
);
    import noc_pkg::*;

    localparam credit_cnt_t FULL_CREDITS = credit_cnt_t'(`BUFFER_DEPTH);

    credit_cnt_t credit_cnt;
    port_idx_t   last_winner;
    port_idx_t   next_winner;

    // Search starts just past the last winner
    always_comb begin
        int  idx;
        logic found;
        idx         = 0;
        found       = 1'b0;
        grant       = '0;
        next_winner = last_winner;
        if (credit_cnt != '0) begin
            for (int k = 1; k <= `NUM_PORTS; k++) begin
                idx = (int'(last_winner) + k) % `NUM_PORTS;
                if (!found && request[idx]) begin
                    grant[idx]  = 1'b1;
                    found       = 1'b1;
                    next_winner = port_idx_t'(idx);
                end
            end
        end
        grant_valid = found;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_winner <= port_idx_t'(`NUM_PORTS - 1);
        end else if (grant_valid) begin
            last_winner <= next_winner;
        end
    end

    // Send and credit in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= FULL_CREDITS;
        end else if (grant_valid && !credit_in) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!grant_valid && credit_in && credit_cnt != FULL_CREDITS) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== router_top.sv ====
// Five-port torus router, one flit per packet; column first then row, ties go east or south
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module router_top #(
    parameter int ROUTER_ID = 0,
    parameter int ROW_COUNT = `DEFAULT_ROWS,
    parameter int COL_COUNT = `DEFAULT_COLS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`NUM_PORTS-1:0] input_valid,
    input  noc_pkg::flit_t        input_data [`NUM_PORTS-1:0],
    input  logic [`NUM_PORTS-2:0] dwnstr_credit_increment,
    output logic [`NUM_PORTS-1:0] out_valid,
    output noc_pkg::flit_t        out_data [`NUM_PORTS-1:0],
    output logic [`NUM_PORTS-2:0] upstr_credit_increment,
    output logic                  nic_credit
);
    import noc_pkg::*;

    localparam int MY_ROW = ROUTER_ID / COL_COUNT;
    localparam int MY_COL = ROUTER_ID % COL_COUNT;

    logic [`NUM_PORTS-1:0] head_valid;
    flit_t                 head_data  [`NUM_PORTS-1:0];
    port_idx_t             route      [`NUM_PORTS-1:0];
    logic [`NUM_PORTS-1:0] pop;
    logic [`NUM_PORTS-1:0] fifo_credit;
    logic [`NUM_PORTS-1:0] arb_credit;
    logic [`NUM_PORTS-1:0] request    [`NUM_PORTS-1:0];
    logic [`NUM_PORTS-1:0] grant      [`NUM_PORTS-1:0];
    logic [`NUM_PORTS-1:0] grant_valid;
    flit_t                 xbar_data  [`NUM_PORTS-1:0];

    // Shorter way around each ring, columns resolved before rows
    function automatic port_idx_t route_port(input node_id_t dest);
        int        d_row;
        int        d_col;
        int        east_hops;
        int        south_hops;
        port_idx_t port;
        d_row      = int'(dest) / COL_COUNT;
        d_col      = int'(dest) % COL_COUNT;
        east_hops  = (d_col - MY_COL + COL_COUNT) % COL_COUNT;
        south_hops = (d_row - MY_ROW + ROW_COUNT) % ROW_COUNT;
        if (east_hops != 0) begin
            port = (east_hops <= COL_COUNT - east_hops) ?
                   port_idx_t'(`EAST) : port_idx_t'(`WEST);
        end else if (south_hops != 0) begin
            port = (south_hops <= ROW_COUNT - south_hops) ?
                   port_idx_t'(`SOUTH) : port_idx_t'(`NORTH);
        end else begin
            port = port_idx_t'(`NIC_PORT);
        end
        return port;
    endfunction

    // Local FIFO credits go back to the NIC, the rest to neighbors
    assign nic_credit             = fifo_credit[`NIC_PORT];
    assign upstr_credit_increment = fifo_credit[`NUM_PORTS-1:1];

    // Ejection never blocks
    assign arb_credit = {dwnstr_credit_increment, 1'b1};

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        flit_fifo u_fifo (
            .clk        (clk),
            .rst_n      (rst_n),
            .push       (input_valid[p]),
            .push_data  (input_data[p]),
            .pop        (pop[p]),
            .head_valid (head_valid[p]),
            .head_data  (head_data[p]),
            .credit_out (fifo_credit[p])
        );

        output_arbiter u_arb (
            .clk         (clk),
            .rst_n       (rst_n),
            .request     (request[p]),
            .credit_in   (arb_credit[p]),
            .grant       (grant[p]),
            .grant_valid (grant_valid[p])
        );
    end

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            route[i] = route_port(head_data[i][`FLIT_DATA_WIDTH-1 -: `DEST_WIDTH]);
        end
    end

    // Request matrix indexed by output, then input
    always_comb begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                request[o][i] = head_valid[i] && (route[i] == port_idx_t'(o));
            end
        end
    end

    // Each head asks for one output, so at most one grant per FIFO
    always_comb begin
        pop = '0;
        for (int o = 0; o < `NUM_PORTS; o++) begin
            pop = pop | grant[o];
        end
    end

    always_comb begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            xbar_data[o] = '0;
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (grant[o][i]) begin
                    xbar_data[o] = head_data[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= grant_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            out_data[o] <= xbar_data[o];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_torus -f files.f -o sim_torus

# The simulator exits nonzero on a failed check, the search below decides
output=$(./obj_dir/sim_torus 2>&1) || true
echo "$output"

if grep -q "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb_torus.sv ====
// Testbench for the default 3x3 torus; torus_patterns.txt must sit in the working directory
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module tb_torus;
    import noc_pkg::*;

    localparam int NODES          = `DEFAULT_ROWS * `DEFAULT_COLS;
    localparam int PAY_W          = `FLIT_DATA_WIDTH - 2 * `DEST_WIDTH;
    localparam int DIRECTED_LIMIT = 2000;
    localparam int RANDOM_LIMIT   = 5000;

    logic             clk;
    logic             rst_n;
    logic [NODES-1:0] nic_output_valid;
    flit_t            nic_output_data [NODES-1:0];
    logic [NODES-1:0] nic_input_valid;
    flit_t            nic_input_data  [NODES-1:0];
    logic [NODES-1:0] nic_credit;

    // Scoreboard queues indexed by source * NODES + destination
    flit_t       inj_q    [NODES][$];
    int          gap_q    [NODES][$];
    flit_t       exp_q    [NODES*NODES][$];
    int          credits  [NODES];
    int          injected [NODES];
    int          returned [NODES];
    int          stall_cycles;
    int          rand_count;
    logic [31:0] lcg_state;
    int          dir_src  [$];
    int          dir_dst  [$];
    int          dir_pay  [$];
    int          dir_gap  [$];

    torus_topology u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .nic_output_valid (nic_output_valid),
        .nic_output_data  (nic_output_data),
        .nic_input_valid  (nic_input_valid),
        .nic_input_data   (nic_input_data),
        .nic_credit       (nic_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_run($sformatf("** Error at %0t ns: %s expected %h, got %h",
                           $time, name, expected, actual));
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    s;
        int    d;
        int    p;
        int    g;
        string line;
        fd = $fopen("torus_patterns.txt", "r");
        assert (fd != 0) else stop_run("Cannot open torus_patterns.txt");
        rand_count = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "/") begin
                continue;
            end
            // Marker line carries the number of random entries
            if (line.getc(0) == "@") begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d", rand_count));
            end else if ($sscanf(line, "%h %h %h %d", s, d, p, g) == 4) begin
                dir_src.push_back(s);
                dir_dst.push_back(d);
                dir_pay.push_back(p);
                dir_gap.push_back(g);
            end
        end
        $fclose(fd);
        assert (dir_src.size() > 0 && rand_count > 0)
            else stop_run("Pattern file holds no directed or no random traffic");
    endtask

    task automatic enqueue(input int src, input int dst, input int pay, input int gap);
        flit_t f;
        assert (src < NODES && dst < NODES)
            else stop_run("Pattern names a node outside the torus");
        f = {node_id_t'(dst), node_id_t'(src), PAY_W'(pay)};
        inj_q[src].push_back(f);
        gap_q[src].push_back(gap);
        exp_q[src*NODES + dst].push_back(f);
    endtask

    task automatic check_arrival(input int k, input flit_t f);
        int src;
        int dst;
        int idx;
        dst = int'(f[`FLIT_DATA_WIDTH-1 -: `DEST_WIDTH]);
        src = int'(f[`FLIT_DATA_WIDTH-`DEST_WIDTH-1 -: `DEST_WIDTH]);
        assert (dst == k)
            else report_mismatch($sformatf("nic_input_data[%0d] dest", k), k, dst);
        assert (src < NODES)
            else stop_run($sformatf("Node %0d got a flit from unknown source %0d", k, src));
        idx = src*NODES + k;
        assert (exp_q[idx].size() > 0)
            else stop_run($sformatf("Node %0d got an unexpected flit from node %0d", k, src));
        assert (f == exp_q[idx][0])
            else report_mismatch($sformatf("nic_input_data[%0d]", k), exp_q[idx][0], f);
        void'(exp_q[idx].pop_front());
    endtask

    // One cycle of sampling outputs, collecting credits and driving injections
    task automatic step();
        @(posedge clk);
        #2;
        for (int k = 0; k < NODES; k++) begin
            if (nic_input_valid[k]) begin
                check_arrival(k, nic_input_data[k]);
            end
            if (nic_credit[k]) begin
                assert (credits[k] < `BUFFER_DEPTH)
                    else stop_run($sformatf("Node %0d got more credits than buffer slots", k));
                credits[k]++;
                returned[k]++;
            end
        end
        for (int k = 0; k < NODES; k++) begin
            nic_output_valid[k] = 1'b0;
            if (inj_q[k].size() > 0) begin
                if (gap_q[k][0] > 0) begin
                    gap_q[k][0] = gap_q[k][0] - 1;
                end else if (credits[k] > 0) begin
                    nic_output_valid[k] = 1'b1;
                    nic_output_data[k]  = inj_q[k].pop_front();
                    void'(gap_q[k].pop_front());
                    credits[k]--;
                    injected[k]++;
                end else begin
                    stall_cycles++;
                end
            end
        end
    endtask

    function automatic logic drained();
        logic idle;
        idle = 1'b1;
        for (int k = 0; k < NODES; k++) begin
            if (inj_q[k].size() != 0) begin
                idle = 1'b0;
            end
        end
        for (int i = 0; i < NODES*NODES; i++) begin
            if (exp_q[i].size() != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic drain(input string phase, input int limit);
        int cycles;
        cycles = 0;
        while (!drained()) begin
            assert (cycles < limit)
                else stop_run($sformatf("Timeout while %s traffic was draining", phase));
            step();
            cycles++;
        end
    endtask

    task automatic add_random_traffic();
        int src;
        int dst;
        int pay;
        int gap;
        for (int i = 0; i < rand_count; i++) begin
            src = int'(next_rand() >> 20) % NODES;
            dst = int'(next_rand() >> 20) % NODES;
            pay = int'(next_rand() >> 16);
            gap = int'(next_rand() >> 30);
            enqueue(src, dst, pay, gap);
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        nic_output_valid = '0;
        for (int k = 0; k < NODES; k++) begin
            nic_output_data[k] = '0;
            credits[k]         = `BUFFER_DEPTH;
            injected[k]        = 0;
            returned[k]        = 0;
        end
        stall_cycles = 0;
        lcg_state    = 32'hb8ca_dfd9;
        load_patterns();

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle network stays silent
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            #2;
            assert (nic_input_valid == '0)
                else report_mismatch("nic_input_valid", 32'h0, 32'(nic_input_valid));
            assert (nic_credit == '0)
                else report_mismatch("nic_credit", 32'h0, 32'(nic_credit));
        end

        for (int i = 0; i < dir_src.size(); i++) begin
            enqueue(dir_src[i], dir_dst[i], dir_pay[i], dir_gap[i]);
        end
        drain("directed", DIRECTED_LIMIT);
        assert (stall_cycles > 0) else stop_run("Hotspot sources never ran out of credits");

        add_random_traffic();
        drain("random", RANDOM_LIMIT);

        // Late or duplicate flits would hit an empty queue here
        repeat (10) step();

        for (int k = 0; k < NODES; k++) begin
            assert (returned[k] == injected[k])
                else report_mismatch($sformatf("nic_credit[%0d] pulses", k),
                                     injected[k], returned[k]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== torus_patterns.txt ====
// source(hex) destination(hex) payload(hex, 16 bit) gap(idle cycles before injection)
// directed entries come first; the line starting with @ gives the number of random entries
// Self and neighbor traffic, node 0 and node 8 use wrap links
4 4 c404 0
4 1 c401 0
4 7 c407 0
4 5 c405 0
4 3 c403 0
0 0 c000 2
0 1 c001 0
0 2 c002 0
0 3 c003 1
0 6 c006 0
8 8 c808 3
8 5 c805 0
8 2 c802 0
8 7 c807 1
8 6 c806 0
// Hotspot toward node 4
1 4 1000 0
1 4 1001 0
1 4 1002 0
1 4 1003 0
1 4 1004 0
1 4 1005 0
1 4 1006 0
1 4 1007 0
1 4 1008 0
1 4 1009 0
1 4 100a 0
3 4 3000 0
3 4 3001 0
3 4 3002 0
3 4 3003 0
3 4 3004 0
3 4 3005 0
3 4 3006 0
3 4 3007 0
3 4 3008 0
3 4 3009 0
3 4 300a 0
7 4 7000 0
7 4 7001 0
7 4 7002 0
7 4 7003 0
7 4 7004 0
7 4 7005 0
7 4 7006 0
7 4 7007 0
7 4 7008 0
7 4 7009 0
7 4 700a 0
@ 80

// ==== torus_topology.sv ====
// Torus of routers with wraparound links; router ids must fit in DEST_WIDTH bits
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module torus_topology #(
    parameter int ROW_COUNT = `DEFAULT_ROWS,
    parameter int COL_COUNT = `DEFAULT_COLS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [ROW_COUNT*COL_COUNT-1:0]   nic_output_valid,
    input  noc_pkg::flit_t                   nic_output_data [ROW_COUNT*COL_COUNT-1:0],
    output logic [ROW_COUNT*COL_COUNT-1:0]   nic_input_valid,
    output noc_pkg::flit_t                   nic_input_data  [ROW_COUNT*COL_COUNT-1:0],
    output logic [ROW_COUNT*COL_COUNT-1:0]   nic_credit
);
    import noc_pkg::*;

    logic [`NUM_PORTS-1:0] rt_in_valid  [ROW_COUNT-1:0][COL_COUNT-1:0];
    flit_t                 rt_in_data   [ROW_COUNT-1:0][COL_COUNT-1:0][`NUM_PORTS-1:0];
    logic [`NUM_PORTS-1:0] rt_out_valid [ROW_COUNT-1:0][COL_COUNT-1:0];
    flit_t                 rt_out_data  [ROW_COUNT-1:0][COL_COUNT-1:0][`NUM_PORTS-1:0];
    logic [`NUM_PORTS-2:0] rt_dwnstr    [ROW_COUNT-1:0][COL_COUNT-1:0];
    logic [`NUM_PORTS-2:0] rt_upstr     [ROW_COUNT-1:0][COL_COUNT-1:0];

    for (genvar i = 0; i < ROW_COUNT; i++) begin : g_row
        for (genvar j = 0; j < COL_COUNT; j++) begin : g_col
            localparam int UP    = (i + ROW_COUNT - 1) % ROW_COUNT;
            localparam int DOWN  = (i + 1) % ROW_COUNT;
            localparam int RIGHT = (j + 1) % COL_COUNT;
            localparam int LEFT  = (j + COL_COUNT - 1) % COL_COUNT;

            // Local injection and ejection
            assign rt_in_valid[i][j][`NIC_PORT]   = nic_output_valid[i*COL_COUNT+j];
            assign rt_in_data[i][j][`NIC_PORT]    = nic_output_data[i*COL_COUNT+j];
            assign nic_input_valid[i*COL_COUNT+j] = rt_out_valid[i][j][`NIC_PORT];
            assign nic_input_data[i*COL_COUNT+j]  = rt_out_data[i][j][`NIC_PORT];

            // North neighbor sits one row up
            assign rt_in_valid[i][j][`NORTH]   = rt_out_valid[UP][j][`SOUTH];
            assign rt_in_data[i][j][`NORTH]    = rt_out_data[UP][j][`SOUTH];
            assign rt_dwnstr[i][j][`NORTH-1]   = rt_upstr[UP][j][`SOUTH-1];

            assign rt_in_valid[i][j][`SOUTH]   = rt_out_valid[DOWN][j][`NORTH];
            assign rt_in_data[i][j][`SOUTH]    = rt_out_data[DOWN][j][`NORTH];
            assign rt_dwnstr[i][j][`SOUTH-1]   = rt_upstr[DOWN][j][`NORTH-1];

            assign rt_in_valid[i][j][`EAST]    = rt_out_valid[i][RIGHT][`WEST];
            assign rt_in_data[i][j][`EAST]     = rt_out_data[i][RIGHT][`WEST];
            assign rt_dwnstr[i][j][`EAST-1]    = rt_upstr[i][RIGHT][`WEST-1];

            assign rt_in_valid[i][j][`WEST]    = rt_out_valid[i][LEFT][`EAST];
            assign rt_in_data[i][j][`WEST]     = rt_out_data[i][LEFT][`EAST];
            assign rt_dwnstr[i][j][`WEST-1]    = rt_upstr[i][LEFT][`EAST-1];

            router_top #(
                .ROUTER_ID (i*COL_COUNT + j),
                .ROW_COUNT (ROW_COUNT),
                .COL_COUNT (COL_COUNT)
            ) u_router (
                .clk                     (clk),
                .rst_n                   (rst_n),
                .input_valid             (rt_in_valid[i][j]),
                .input_data              (rt_in_data[i][j]),
                .dwnstr_credit_increment (rt_dwnstr[i][j]),
                .out_valid               (rt_out_valid[i][j]),
                .out_data                (rt_out_data[i][j]),
                .upstr_credit_increment  (rt_upstr[i][j]),
                .nic_credit              (nic_credit[i*COL_COUNT+j])
            );
        end
    end

endmodule

`default_nettype wire
